/* logic/cpu_pkg.sv */
package cpu_pkg;

  // Word and field widths, fixed by the instruction format
  localparam int data_w     = 32;
  localparam int half_w     = 16;  // Also the immediate width
  localparam int reg_addr_w = 3;
  localparam int num_regs   = 8;
  localparam int op_w       = 3;

  // Instruction type field
  localparam logic [1:0] type_nop   = 2'b00;
  localparam logic [1:0] type_arith = 2'b01;
  localparam logic [1:0] type_mem   = 2'b10;  // Decoded as no-op
  localparam logic [1:0] type_audio = 2'b11;  // Decoded as no-op

  // Arithmetic-type operations
  localparam logic [op_w-1:0] op_add     = 3'b001;
  localparam logic [op_w-1:0] op_inc     = 3'b011;
  localparam logic [op_w-1:0] op_mov_lo  = 3'b101;
  localparam logic [op_w-1:0] op_mov_hi  = 3'b110;
  localparam logic [op_w-1:0] op_mov_reg = 3'b111;

  // Bit 0 writes the low half, bit 1 the high half
  typedef logic [1:0] wmask_t;

  // Same word seen as register form or immediate form
  typedef union packed {
    struct packed {
      logic                  imm_flag;
      logic [1:0]            itype;
      logic [op_w-1:0]       op;
      logic [1:0]            rsvd_ch;   // Audio channel in the full ISA
      logic [1:0]            rsvd;
      logic [reg_addr_w-1:0] src_a;     // Also the destination
      logic [reg_addr_w-1:0] src_b;
      logic [half_w-1:0]     rsvd_lo;
    } r;
    struct packed {
      logic                  imm_flag;
      logic [1:0]            itype;
      logic [op_w-1:0]       op;
      logic [1:0]            rsvd_ch;
      logic [1:0]            rsvd;
      logic [reg_addr_w-1:0] src_a;
      logic [reg_addr_w-1:0] src_b;
      logic [half_w-1:0]     imm;
    } i;
  } instr_t;

endpackage

/* logic/pc_counter.sv */
module pc_counter #(
  parameter int pc_w = 15
) (
  input  logic            clk,
  input  logic            resetn,
  input  logic            stall,
  output logic [pc_w-1:0] pc
);

  logic [pc_w-1:0] pc_q;
  logic [pc_w-1:0] pc_next;

  // Hold the fetch address while decode is blocked
  always_comb begin
    if (stall) begin
      pc_next = pc_q;
    end else begin
      pc_next = pc_q + pc_w'(1);  // Wraps at pc_w bits
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

endmodule

/* logic/hazard_unit.sv */
module hazard_unit import cpu_pkg::*; (
  input  logic [reg_addr_w-1:0] id_src_a,
  input  logic [reg_addr_w-1:0] id_src_b,
  input  logic                  id_uses_b,
  input  logic                  id_writes,
  input  logic [reg_addr_w-1:0] ex_dest,
  input  wmask_t                ex_mask,
  input  logic [reg_addr_w-1:0] wb_dest,
  input  wmask_t                wb_mask,
  output logic                  stall
);

  logic ex_busy;
  logic wb_busy;
  logic hit_ex;
  logic hit_wb;

  // Only writing instructions in flight can create a conflict
  assign ex_busy = |ex_mask;
  assign wb_busy = |wb_mask;

  // src_a is always read, src_b only for some operations
  always_comb begin
    hit_ex = 1'b0;
    hit_wb = 1'b0;
    if (ex_busy) begin
      if (ex_dest == id_src_a) begin
        hit_ex = 1'b1;
      end
      if (id_uses_b && (ex_dest == id_src_b)) begin
        hit_ex = 1'b1;
      end
    end
    if (wb_busy) begin
      if (wb_dest == id_src_a) begin
        hit_wb = 1'b1;
      end
      if (id_uses_b && (wb_dest == id_src_b)) begin
        hit_wb = 1'b1;
      end
    end
  end

  // No bypass in the register file, so wait until writeback lands
  assign stall = id_writes && (hit_ex || hit_wb);

endmodule

/* logic/decode_stage.sv */
module decode_stage import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  stall,
  input  logic [data_w-1:0]     imem_data,
  output logic [reg_addr_w-1:0] rd_sel_a,
  output logic [reg_addr_w-1:0] rd_sel_b,
  input  logic [data_w-1:0]     rd_val_a,
  input  logic [data_w-1:0]     rd_val_b,
  output logic [reg_addr_w-1:0] id_src_a,
  output logic [reg_addr_w-1:0] id_src_b,
  output logic                  id_uses_b,
  output logic                  id_writes,
  output logic [op_w-1:0]       ex_op,
  output logic [data_w-1:0]     ex_opnd_a,
  output logic [data_w-1:0]     ex_opnd_b,
  output logic [reg_addr_w-1:0] ex_dest,
  output wmask_t                ex_mask,
  output logic                  ex_is_move
);

  instr_t              ir;
  logic [data_w-1:0]   imm_lo;
  logic [data_w-1:0]   imm_hi;
  logic [data_w-1:0]   opnd_b;
  wmask_t              mask;
  logic                is_move;

  // Instruction register frozen during a stall
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ir <= '0;  // All zero is a no-op
    end else if (!stall) begin
      ir <= imem_data;
    end
  end

  assign id_src_a = ir.r.src_a;
  assign id_src_b = ir.r.src_b;
  assign rd_sel_a = id_src_a;
  assign rd_sel_b = id_src_b;

  // Immediate placed in either half
  assign imm_lo = {{(data_w-half_w){1'b0}}, ir.i.imm};
  assign imm_hi = {ir.i.imm, {(data_w-half_w){1'b0}}};

  always_comb begin
    case (ir.r.itype)
      type_arith: id_writes = 1'b1;
      type_nop, type_mem, type_audio: id_writes = 1'b0;  // Memory and audio retire nothing
      default: id_writes = 1'b0;
    endcase
  end

  assign is_move = id_writes && ((ir.r.op == op_mov_lo) || (ir.r.op == op_mov_hi) ||
                                 (ir.r.op == op_mov_reg));

  // Register add and move register read src_b
  assign id_uses_b = id_writes &&
                     (((ir.r.op == op_add) && !ir.r.imm_flag) || (ir.r.op == op_mov_reg));

  // Operand b and half-word mask
  always_comb begin
    opnd_b = rd_val_b;
    mask   = 2'b11;
    case (ir.r.op)
      op_mov_lo: begin
        opnd_b = imm_lo;
        mask   = 2'b01;
      end
      op_mov_hi: begin
        opnd_b = imm_hi;
        mask   = 2'b10;
      end
      op_add: begin
        if (ir.r.imm_flag) begin
          opnd_b = imm_lo;  // Zero-extended add immediate
        end
      end
      default: opnd_b = rd_val_b;  // Move register and the rest
    endcase
    // Bubble on stall or non-writing type
    if (!id_writes || stall) begin
      mask = 2'b00;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ex_op      <= '0;
      ex_dest    <= '0;
      ex_mask    <= 2'b00;
      ex_is_move <= 1'b0;
    end else begin
      ex_op      <= ir.r.op;
      ex_dest    <= ir.r.src_a;
      ex_mask    <= mask;
      ex_is_move <= is_move;
    end
  end

  // Operand values
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ex_opnd_a <= '0;
      ex_opnd_b <= '0;
    end else begin
      ex_opnd_a <= rd_val_a;
      ex_opnd_b <= opnd_b;
    end
  end

endmodule

/* logic/execute_stage.sv */
module execute_stage import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [op_w-1:0]       ex_op,
  input  logic [data_w-1:0]     ex_opnd_a,
  input  logic [data_w-1:0]     ex_opnd_b,
  input  logic [reg_addr_w-1:0] ex_dest,
  input  wmask_t                ex_mask,
  input  logic                  ex_is_move,
  output logic [reg_addr_w-1:0] wb_dest,
  output wmask_t                wb_mask,
  output logic [data_w-1:0]     wb_data
);

  logic [data_w-1:0] alu_result;
  logic [data_w-1:0] result;

  // Adder ALU
  always_comb begin
    case (ex_op)
      op_add:  alu_result = ex_opnd_a + ex_opnd_b;
      op_inc:  alu_result = ex_opnd_a + data_w'(1);
      default: alu_result = '0;  // Undefined ops write zero
    endcase
  end

  // Moves carry their value in operand b
  always_comb begin
    if (ex_is_move) begin
      result = ex_opnd_b;
    end else begin
      result = alu_result;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wb_dest <= '0;
      wb_mask <= 2'b00;
    end else begin
      wb_dest <= ex_dest;
      wb_mask <= ex_mask;  // Stage never holds
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wb_data <= '0;
    end else begin
      wb_data <= result;
    end
  end

endmodule

/* logic/reg_file.sv */
module reg_file import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [reg_addr_w-1:0] rd_sel_a,
  input  logic [reg_addr_w-1:0] rd_sel_b,
  output logic [data_w-1:0]     rd_val_a,
  output logic [data_w-1:0]     rd_val_b,
  input  logic [reg_addr_w-1:0] wr_dest,
  input  wmask_t                wr_mask,
  input  logic [data_w-1:0]     wr_data,
  input  logic [reg_addr_w-1:0] dbg_sel,
  output logic [data_w-1:0]     dbg_value
);

  logic [data_w-1:0] regs [num_regs];

  // Each half written on its own mask bit
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_mask[0]) begin
        regs[wr_dest][half_w-1:0] <= wr_data[half_w-1:0];
      end
      if (wr_mask[1]) begin
        regs[wr_dest][data_w-1:half_w] <= wr_data[data_w-1:half_w];
      end
    end
  end

  // Plain reads, a write shows up after the edge
  assign rd_val_a  = regs[rd_sel_a];
  assign rd_val_b  = regs[rd_sel_b];
  assign dbg_value = regs[dbg_sel];  // Debug port

endmodule

/* logic/cpu_core.sv */
module cpu_core import cpu_pkg::*; #(
  parameter int pc_w = 15
) (
  input  logic                  clk,
  input  logic                  resetn,
  output logic [pc_w-1:0]       imem_addr,
  input  logic [data_w-1:0]     imem_data,
  output logic                  stall,
  output logic                  retire_valid,
  output logic [reg_addr_w-1:0] retire_dest,
  output wmask_t                retire_mask,
  output logic [data_w-1:0]     retire_data,
  input  logic [reg_addr_w-1:0] dbg_sel,
  output logic [data_w-1:0]     dbg_value
);

  logic [reg_addr_w-1:0] rd_sel_a;
  logic [reg_addr_w-1:0] rd_sel_b;
  logic [data_w-1:0]     rd_val_a;
  logic [data_w-1:0]     rd_val_b;
  logic [reg_addr_w-1:0] id_src_a;
  logic [reg_addr_w-1:0] id_src_b;
  logic                  id_uses_b;
  logic                  id_writes;
  logic [op_w-1:0]       ex_op;
  logic [data_w-1:0]     ex_opnd_a;
  logic [data_w-1:0]     ex_opnd_b;
  logic [reg_addr_w-1:0] ex_dest;
  wmask_t                ex_mask;
  logic                  ex_is_move;

  pc_counter #(.pc_w(pc_w)) u_pc (
    .clk(clk), .resetn(resetn), .stall(stall), .pc(imem_addr)
  );

  decode_stage u_decode (
    .clk(clk), .resetn(resetn), .stall(stall), .imem_data(imem_data),
    .rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b), .rd_val_a(rd_val_a), .rd_val_b(rd_val_b),
    .id_src_a(id_src_a), .id_src_b(id_src_b), .id_uses_b(id_uses_b), .id_writes(id_writes),
    .ex_op(ex_op), .ex_opnd_a(ex_opnd_a), .ex_opnd_b(ex_opnd_b), .ex_dest(ex_dest),
    .ex_mask(ex_mask), .ex_is_move(ex_is_move)
  );

  // Writeback register doubles as the retire port
  execute_stage u_execute (
    .clk(clk), .resetn(resetn),
    .ex_op(ex_op), .ex_opnd_a(ex_opnd_a), .ex_opnd_b(ex_opnd_b), .ex_dest(ex_dest),
    .ex_mask(ex_mask), .ex_is_move(ex_is_move),
    .wb_dest(retire_dest), .wb_mask(retire_mask), .wb_data(retire_data)
  );

  hazard_unit u_hazard (
    .id_src_a(id_src_a), .id_src_b(id_src_b), .id_uses_b(id_uses_b), .id_writes(id_writes),
    .ex_dest(ex_dest), .ex_mask(ex_mask),
    .wb_dest(retire_dest), .wb_mask(retire_mask),
    .stall(stall)
  );

  reg_file u_regs (
    .clk(clk), .resetn(resetn),
    .rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b), .rd_val_a(rd_val_a), .rd_val_b(rd_val_b),
    .wr_dest(retire_dest), .wr_mask(retire_mask), .wr_data(retire_data),
    .dbg_sel(dbg_sel), .dbg_value(dbg_value)
  );

  assign retire_valid = |retire_mask;  // One pulse per writing instruction

endmodule

/* verif/tb_clock.sv */
module tb_clock (
  input  logic reset_req,
  output logic clk,
  output logic resetn
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period  = 4;  // 8 ns clock
  localparam int reset_cycles = 10;

  int hold_cnt;

  initial begin
    clk      = 1'b0;
    resetn   = 1'b0;
    hold_cnt = reset_cycles;
    forever begin
      #half_period;
      clk = ~clk;
    end
  end

  // Count edges while in reset, restart on request
  always @(posedge clk) begin
    if (reset_req) begin
      hold_cnt <= reset_cycles;
    end else if (hold_cnt > 0) begin
      hold_cnt <= hold_cnt - 1;
    end
  end

  // Reset moves just after the edge, like the other DUT inputs
  always @(posedge clk) begin
    #1;
    resetn = (hold_cnt == 0);
  end

endmodule

/* verif/tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int pc_w      = 15;
  localparam int rom_depth = 256;

  logic                  clk;
  logic                  resetn;
  logic                  reset_req;
  logic [pc_w-1:0]       imem_addr;
  logic [data_w-1:0]     imem_data;
  logic                  stall;
  logic                  retire_valid;
  logic [reg_addr_w-1:0] retire_dest;
  wmask_t                retire_mask;
  logic [data_w-1:0]     retire_data;
  logic [reg_addr_w-1:0] dbg_sel;
  logic [data_w-1:0]     dbg_value;

  logic [data_w-1:0]     rom [rom_depth];
  logic [data_w-1:0]     m_regs [num_regs];  // Model register file
  logic [reg_addr_w-1:0] exp_dest [$];
  logic [1:0]            exp_mask [$];
  logic [data_w-1:0]     exp_data [$];
  logic [31:0]           lfsr;
  int                    err_count;
  int                    test_count;
  int                    fail_count;

  tb_clock u_clk (.reset_req(reset_req), .clk(clk), .resetn(resetn));

  cpu_core #(.pc_w(pc_w)) u_dut (
    .clk(clk), .resetn(resetn), .imem_addr(imem_addr), .imem_data(imem_data),
    .stall(stall), .retire_valid(retire_valid), .retire_dest(retire_dest),
    .retire_mask(retire_mask), .retire_data(retire_data),
    .dbg_sel(dbg_sel), .dbg_value(dbg_value)
  );

  // Instruction memory, zero (no-op) past the end
  assign imem_data = (imem_addr < rom_depth) ? rom[imem_addr[7:0]] : '0;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // kind 0 moves, 1 arithmetic, 2 dependent chain, 3 any type, 4 weighted mix
  function automatic logic [data_w-1:0] rand_instr(input int kind, input logic [2:0] chain);
    logic [2:0]  pick;
    logic [1:0]  ty;
    logic [2:0]  op;
    logic [2:0]  a;
    logic [2:0]  b;
    logic        imm_f;
    logic [15:0] imm;
    pick  = 3'(rand_bits(3));
    ty    = type_arith;
    op    = 3'(rand_bits(3));
    a     = 3'(rand_bits(3));
    b     = 3'(rand_bits(3));
    imm_f = rand_bits(1) != 0;
    imm   = 16'(rand_bits(16));
    case (kind)
      0: op = (pick < 3) ? op_mov_lo : (pick < 6) ? op_mov_hi : op_mov_reg;
      1: op = (pick < 3) ? op_add : (pick < 5) ? op_inc : 3'((pick - 3'd5) << 1);
      2: begin
        a  = chain;
        b  = chain;
        op = (pick == 0) ? op_mov_lo : pick[0] ? op_inc : op_add;
      end
      3: ty = 2'(rand_bits(2));
      default: ty = (pick < 5) ? type_arith : (pick == 5) ? type_nop : pick[1:0];
    endcase
    return {imm_f, ty, op, 4'h0, a, b, imm};
  endfunction

  task automatic gen_program(input int kind, input int n);
    logic [2:0] chain;
    chain = '0;
    for (int i = 0; i < rom_depth; i++) begin
      rom[i] = '0;
    end
    for (int i = 0; i < n; i++) begin
      if (i % 4 == 0) begin
        chain = 3'(rand_bits(3));  // New chain register every few instructions
      end
      rom[i] = rand_instr(kind, chain);
    end
  endtask

  // Sequential ISA model, fills the expected retire queues
  task automatic run_model(input int n);
    logic [data_w-1:0] w;
    logic [data_w-1:0] val;
    logic [1:0]        mask;
    logic [2:0]        a;
    logic [2:0]        b;
    exp_dest.delete();
    exp_mask.delete();
    exp_data.delete();
    for (int r = 0; r < num_regs; r++) begin
      m_regs[r] = '0;
    end
    for (int i = 0; i < n; i++) begin
      w    = rom[i];
      a    = w[21:19];
      b    = w[18:16];
      mask = 2'b11;
      case (w[28:26])
        op_mov_lo: begin
          mask = 2'b01;
          val  = {16'h0, w[15:0]};
        end
        op_mov_hi: begin
          mask = 2'b10;
          val  = {w[15:0], 16'h0};
        end
        op_mov_reg: val = m_regs[b];
        op_add:     val = m_regs[a] + (w[31] ? {16'h0, w[15:0]} : m_regs[b]);
        op_inc:     val = m_regs[a] + 1;
        default:    val = '0;  // Undefined op clears the register
      endcase
      if (w[30:29] == type_arith) begin
        if (mask[0]) begin
          m_regs[a][15:0] = val[15:0];
        end
        if (mask[1]) begin
          m_regs[a][31:16] = val[31:16];
        end
        exp_dest.push_back(a);
        exp_mask.push_back(mask);
        exp_data.push_back(val);
      end
    end
  endtask

  task automatic wait_reset(input logic level);
    int cycles;
    cycles = 0;
    while (resetn !== level && cycles < 40) begin
      @(negedge clk);
      cycles++;
    end
    if (resetn !== level) begin
      $display("Reset did not reach level %0d within 40 cycles", level);
      err_count++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset_req = 1'b1;
    @(posedge clk);
    #1;
    reset_req = 1'b0;
    wait_reset(1'b0);
    wait_reset(1'b1);
  endtask

  task automatic check_retire();
    logic [data_w-1:0] keep;
    if (exp_dest.size() == 0) begin
      $display("Retire event to r%0d with no writing instruction left", retire_dest);
      err_count++;
    end else begin
      keep = {{16{exp_mask[0][1]}}, {16{exp_mask[0][0]}}};  // Only written halves
      if (retire_dest !== exp_dest[0]) begin
        $display("ERR retire_dest got %h exp %h", retire_dest, exp_dest[0]);
        err_count++;
      end
      if (retire_mask !== exp_mask[0]) begin
        $display("ERR retire_mask got %h exp %h", retire_mask, exp_mask[0]);
        err_count++;
      end
      if ((retire_data & keep) !== (exp_data[0] & keep)) begin
        $display("ERR retire_data got %h exp %h", retire_data & keep, exp_data[0] & keep);
        err_count++;
      end
      void'(exp_dest.pop_front());
      void'(exp_mask.pop_front());
      void'(exp_data.pop_front());
    end
  endtask

  task automatic check_regs();
    for (int r = 0; r < num_regs; r++) begin
      @(posedge clk);
      #1;
      dbg_sel = 3'(r);
      @(negedge clk);
      if (dbg_value !== m_regs[r]) begin
        $display("ERR dbg_value r%0d got %h exp %h", r, dbg_value, m_regs[r]);
        err_count++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before, input string detail);
    test_count++;
    if (err_count != errs_before) begin
      fail_count++;
      $display("%-9s FAIL  %s", name, detail);
    end else begin
      $display("%-9s PASS  %s", name, detail);
    end
  endtask

  task automatic check_after_reset();
    int errs_before;
    errs_before = err_count;
    wait_reset(1'b1);
    if (imem_addr !== '0) begin
      $display("ERR imem_addr got %h exp %h", imem_addr, 15'h0);
      err_count++;
    end
    if (retire_valid !== 1'b0 || stall !== 1'b0) begin
      $display("ERR retire_valid/stall got %h/%h exp 0/0", retire_valid, stall);
      err_count++;
    end
    for (int r = 0; r < num_regs; r++) begin
      m_regs[r] = '0;
    end
    check_regs();
    report_test("reset", errs_before, "all registers read zero");
  endtask

  task automatic run_test(input string name, input int kind, input int n);
    int errs_before;
    int cycles;
    int retired;
    int stalls;
    int expected;
    errs_before = err_count;
    gen_program(kind, n);
    run_model(n);
    expected = exp_dest.size();
    apply_reset();
    cycles  = 0;
    retired = 0;
    stalls  = 0;
    // Until the last instruction has passed writeback
    while (int'(imem_addr) < n + 4 && cycles < 4 * n + 40) begin
      @(negedge clk);
      cycles++;
      if (stall) begin
        stalls++;
      end
      if (retire_valid) begin
        retired++;
        check_retire();
      end
    end
    if (int'(imem_addr) < n + 4) begin
      $display("%s: timed out before the program drained", name);
      err_count++;
    end
    if (exp_dest.size() != 0) begin
      $display("%s: %0d expected retire events never came", name, exp_dest.size());
      err_count++;
    end
    if (kind == 2 && stalls == 0) begin
      $display("%s: stall never went high on dependent chains", name);
      err_count++;
    end
    check_regs();
    report_test(name, errs_before, $sformatf("%0d instr, retired %0d of %0d, %0d stall cycles",
                                             n, retired, expected, stalls));
  endtask

  initial begin
    reset_req  = 1'b0;
    dbg_sel    = '0;
    lfsr       = 32'h37e6;
    err_count  = 0;
    test_count = 0;
    fail_count = 0;
    for (int i = 0; i < rom_depth; i++) begin
      rom[i] = '0;
    end
    check_after_reset();
    run_test("moves", 0, 40);
    run_test("arith", 1, 60);
    run_test("hazards", 2, 48);
    run_test("ignored", 3, 60);
    run_test("long_mix", 4, 200);
    $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* project.f */
logic/cpu_pkg.sv
logic/pc_counter.sv
logic/hazard_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/reg_file.sv
logic/cpu_core.sv
verif/tb_clock.sv
verif/tb_cpu.sv
